/* ring_lock.f */
ring_lock_pkg.sv
lock_step_if.sv
lock_cfg_regs.sv
lock_sequencer.sv
slope_window.sv
tune_code_gen.sv
ring_lock_top.sv
tb_ring_lock.sv

/* tb_ring_lock.sv */
// Ring lock controller testbench
module tb_ring_lock;

  // Cycles any single wait may take
  localparam int TIMEOUT    = 50;
  localparam int SEL_TRIG   = 0;
  localparam int SEL_TUNE   = 1;
  localparam int SEL_COMMIT = 2;
  localparam int SEL_LOCK   = 3;

  logic                                   i_clk;
  logic                                   i_rst;
  ring_lock_pkg::tune_code_t              i_cfg_tune_start;
  logic [ring_lock_pkg::STRIDE_WIDTH-1:0] i_cfg_tune_stride;
  logic                                   i_trig_val;
  logic                                   o_trig_rdy;
  logic                                   i_lock_stop;
  logic                                   o_tune_val;
  logic                                   i_tune_ack;
  ring_lock_pkg::tune_code_t              o_ring_tune;
  logic                                   o_commit_rdy;
  logic                                   i_commit_ack;
  ring_lock_pkg::pwr_t                    i_pwr_commit;
  logic                                   o_locked;

  int checks;
  int errors;
  int err_mark;

  // ----------------------------------------------------------------------
  // Reference model state, one update per transaction
  // ----------------------------------------------------------------------
  ring_lock_pkg::tune_code_t             m_base;
  ring_lock_pkg::tune_code_t             m_delta;
  ring_lock_pkg::tune_code_t             m_step;
  ring_lock_pkg::track_state_e           m_track;
  int                                    m_cnt;
  logic [ring_lock_pkg::WINDOW_SIZE-1:0] m_rise;
  logic [ring_lock_pkg::WINDOW_SIZE-1:0] m_fall;
  ring_lock_pkg::pwr_t                   m_prev;
  logic                                  m_prev_vld;
  // Codes seen at each tune ack of the current lock
  ring_lock_pkg::tune_code_t             codes[$];

  ring_lock_top i_dut (
    .i_clk             (i_clk),
    .i_rst             (i_rst),
    .i_cfg_tune_start  (i_cfg_tune_start),
    .i_cfg_tune_stride (i_cfg_tune_stride),
    .i_trig_val        (i_trig_val),
    .o_trig_rdy        (o_trig_rdy),
    .i_lock_stop       (i_lock_stop),
    .o_tune_val        (o_tune_val),
    .i_tune_ack        (i_tune_ack),
    .o_ring_tune       (o_ring_tune),
    .o_commit_rdy      (o_commit_rdy),
    .i_commit_ack      (i_commit_ack),
    .i_pwr_commit      (i_pwr_commit),
    .o_locked          (o_locked)
  );

  always #5 i_clk = ~i_clk;

  // ----------------------------------------------------------------------
  // Compare tasks
  // ----------------------------------------------------------------------
  task automatic check_code(input ring_lock_pkg::tune_code_t got,
                            input ring_lock_pkg::tune_code_t exp, input string msg);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Mismatch at %0t: %s, got 0x%02h expected 0x%02h", $time, msg, got, exp);
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string msg);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Mismatch at %0t: %s, got %b expected %b", $time, msg, got, exp);
    end
  endtask

  // Never both handshakes open at once
  always @(negedge i_clk) begin
    if (!i_rst) check_flag(o_tune_val && o_commit_rdy, 1'b0, "tune val with commit rdy");
  end

  // ----------------------------------------------------------------------
  // Model
  // ----------------------------------------------------------------------
  function automatic int ones_in(input logic [ring_lock_pkg::WINDOW_SIZE-1:0] v);
    int n;
    n = 0;
    for (int i = 0; i < ring_lock_pkg::WINDOW_SIZE; i++) n += v[i];
    return n;
  endfunction

  task automatic init_model(input ring_lock_pkg::tune_code_t start, input int stride);
    m_base     = start;
    m_delta    = '0;
    // Step is two to the stride
    m_step     = ring_lock_pkg::tune_code_t'(2 ** stride);
    m_track    = ring_lock_pkg::TRACK_DELTA;
    m_cnt      = 0;
    m_rise     = '0;
    m_fall     = '0;
    m_prev_vld = 1'b0;
  endtask

  task automatic predict_code(output ring_lock_pkg::tune_code_t code);
    int nr;
    int nf;
    nr = ones_in(m_rise);
    nf = ones_in(m_fall);
    if (m_track == ring_lock_pkg::TRACK_DELTA) begin
      m_delta = m_delta + m_step;
    end else begin
      // Majority vote, a tie or no majority holds the base
      if (nr >= ring_lock_pkg::VOTE_THRES && nf < ring_lock_pkg::VOTE_THRES)
        m_base = m_base + m_step;
      else if (nf >= ring_lock_pkg::VOTE_THRES && nr < ring_lock_pkg::VOTE_THRES)
        m_base = m_base - m_step;
      m_delta = '0;
    end
    code = m_base + m_delta;
  endtask

  task automatic apply_commit(input ring_lock_pkg::pwr_t p);
    if (m_track == ring_lock_pkg::TRACK_DELTA) begin
      // First sample of a lock only primes the compare
      if (m_prev_vld) begin
        m_rise = {m_rise[ring_lock_pkg::WINDOW_SIZE-2:0], p > m_prev};
        m_fall = {m_fall[ring_lock_pkg::WINDOW_SIZE-2:0], p < m_prev};
      end
      m_prev     = p;
      m_prev_vld = 1'b1;
      m_cnt++;
      if (m_cnt == ring_lock_pkg::WINDOW_SIZE) m_track = ring_lock_pkg::TRACK_DETECT;
    end else begin
      m_track = ring_lock_pkg::TRACK_DELTA;
      m_cnt   = 0;
    end
  endtask

  // Mode 1 rising, 2 falling, 3 flat, otherwise random
  function automatic ring_lock_pkg::pwr_t power_for(input int mode, input int idx);
    case (mode)
      1:       return ring_lock_pkg::pwr_t'(20 + 3 * idx);
      2:       return ring_lock_pkg::pwr_t'(230 - 3 * idx);
      3:       return ring_lock_pkg::pwr_t'(128);
      default: return ring_lock_pkg::pwr_t'($urandom_range(0, 255));
    endcase
  endfunction

  // ----------------------------------------------------------------------
  // Handshake helpers, all entered and left at a falling edge
  // ----------------------------------------------------------------------
  function automatic logic level_of(input int sel);
    case (sel)
      SEL_TRIG:   return o_trig_rdy;
      SEL_TUNE:   return o_tune_val;
      SEL_COMMIT: return o_commit_rdy;
      default:    return o_locked;
    endcase
  endfunction

  task automatic wait_for(input int sel, input logic lvl, input string what);
    int n;
    n = 0;
    while (level_of(sel) !== lvl && n < TIMEOUT) begin
      @(negedge i_clk);
      n++;
    end
    if (level_of(sel) !== lvl) begin
      $display("Timeout after %0d cycles waiting for %s", TIMEOUT, what);
      $display("Test FAILED");
      $finish;
    end
  endtask

  task automatic start_lock(input ring_lock_pkg::tune_code_t start, input int stride);
    @(posedge i_clk);
    i_cfg_tune_start  <= start;
    i_cfg_tune_stride <= stride[ring_lock_pkg::STRIDE_WIDTH-1:0];
    i_trig_val        <= 1'b1;
    @(posedge i_clk);
    i_trig_val <= 1'b0;
    @(negedge i_clk);
    wait_for(SEL_LOCK, 1'b1, "locked after trigger");
    init_model(start, stride);
    codes.delete();
  endtask

  task automatic stop_lock();
    @(posedge i_clk);
    i_lock_stop <= 1'b1;
    @(posedge i_clk);
    i_lock_stop <= 1'b0;
    @(negedge i_clk);
    wait_for(SEL_TRIG, 1'b1, "trigger ready after stop");
    check_flag(o_tune_val, 1'b0, "tune val after stop");
    check_flag(o_commit_rdy, 1'b0, "commit rdy after stop");
    check_flag(o_locked, 1'b0, "locked after stop");
  endtask

  // One tune and commit iteration with random ack delays
  // Noise pulses the other ack while it must be ignored
  task automatic run_step(input int mode, input int idx, input bit noise);
    ring_lock_pkg::tune_code_t exp;
    ring_lock_pkg::pwr_t       p;
    int                        d;
    predict_code(exp);
    wait_for(SEL_TUNE, 1'b1, "tune val");
    d = $urandom_range(0, 3);
    repeat (d) begin
      @(posedge i_clk);
      if (noise) i_commit_ack <= 1'($urandom_range(0, 1));
      @(negedge i_clk);
      check_flag(o_tune_val, 1'b1, "tune val held before ack");
    end
    check_code(o_ring_tune, exp, "ring tune code");
    codes.push_back(o_ring_tune);
    @(posedge i_clk);
    i_tune_ack   <= 1'b1;
    i_commit_ack <= 1'b0;
    @(negedge i_clk);
    check_flag(o_tune_val, 1'b1, "tune val held until ack seen");
    @(posedge i_clk);
    i_tune_ack <= 1'b0;
    @(negedge i_clk);
    check_flag(o_tune_val, 1'b0, "tune val after ack");
    wait_for(SEL_COMMIT, 1'b1, "commit rdy");
    d = $urandom_range(0, 3);
    repeat (d) begin
      @(posedge i_clk);
      if (noise) i_tune_ack <= 1'($urandom_range(0, 1));
      @(negedge i_clk);
      check_flag(o_commit_rdy, 1'b1, "commit rdy held before ack");
    end
    p = power_for(mode, idx);
    @(posedge i_clk);
    i_commit_ack <= 1'b1;
    i_tune_ack   <= 1'b0;
    i_pwr_commit <= p;
    @(posedge i_clk);
    i_commit_ack <= 1'b0;
    apply_commit(p);
    @(negedge i_clk);
    check_flag(o_commit_rdy, 1'b0, "commit rdy after ack");
  endtask

  task automatic report_test(input string name);
    if (errors == err_mark) $display("test %s: pass", name);
    else $display("test %s: fail with %0d errors", name, errors - err_mark);
    err_mark = errors;
  endtask

  // ----------------------------------------------------------------------
  // Test sequence
  // ----------------------------------------------------------------------
  initial begin
    void'($urandom(32'h67a7));
    checks            = 0;
    errors            = 0;
    err_mark          = 0;
    i_clk             = 1'b0;
    i_rst             = 1'b1;
    i_cfg_tune_start  = '0;
    i_cfg_tune_stride = '0;
    i_trig_val        = 1'b0;
    i_lock_stop       = 1'b0;
    i_tune_ack        = 1'b0;
    i_commit_ack      = 1'b0;
    i_pwr_commit      = '0;
    repeat (3) @(posedge i_clk);
    i_rst <= 1'b0;
    @(negedge i_clk);

    // Reset levels, then first code is start plus step
    check_flag(o_trig_rdy, 1'b1, "trig rdy after reset");
    check_flag(o_tune_val, 1'b0, "tune val after reset");
    check_flag(o_commit_rdy, 1'b0, "commit rdy after reset");
    check_flag(o_locked, 1'b0, "locked after reset");
    check_code(o_ring_tune, '0, "ring tune after reset");
    start_lock(8'h40, 2);
    run_step(0, 0, 1'b0);
    check_code(codes[0], 8'h44, "first code");
    stop_lock();
    report_test("reset and first code");

    // Rising power ramps then steps the base up
    start_lock(8'h60, 3);
    for (int i = 0; i < 10; i++) run_step(1, i, 1'b0);
    check_code(codes[4], 8'h68, "code after rising detect");
    stop_lock();
    report_test("rising power");

    // Falling power steps down, flat power holds
    start_lock(8'h80, 1);
    for (int i = 0; i < 10; i++) run_step(2, i, 1'b0);
    check_code(codes[4], 8'h7e, "code after falling detect");
    stop_lock();
    start_lock(8'h30, 4);
    for (int i = 0; i < 10; i++) run_step(3, i, 1'b0);
    check_code(codes[4], 8'h30, "code after flat detect");
    stop_lock();
    report_test("falling and flat power");

    // Random power and back-pressure over many windows
    for (int k = 0; k < 3; k++) begin
      start_lock(ring_lock_pkg::tune_code_t'($urandom), $urandom_range(0, 7));
      for (int i = 0; i < 40; i++) run_step(0, i, 1'b1);
      stop_lock();
    end
    report_test("random power");

    // Config moves mid lock are ignored until the retrigger
    start_lock(8'h20, 1);
    for (int i = 0; i < 3; i++) run_step(0, i, 1'b0);
    @(posedge i_clk);
    i_cfg_tune_start  <= 8'ha0;
    i_cfg_tune_stride <= 3'd5;
    @(negedge i_clk);
    for (int i = 0; i < 8; i++) run_step(0, i, 1'b1);
    // Stop with a tune val still pending
    wait_for(SEL_TUNE, 1'b1, "pending tune val");
    stop_lock();
    start_lock(8'ha0, 5);
    run_step(0, 0, 1'b0);
    check_code(codes[0], 8'hc0, "first code after retrigger");
    stop_lock();
    report_test("config hold and restart");

    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

/* ring_lock_top.sv */
// Ring resonator lock controller
module ring_lock_top (
  input  logic                                   i_clk,
  input  logic                                   i_rst,
  // Per-lock config
  input  ring_lock_pkg::tune_code_t              i_cfg_tune_start,
  input  logic [ring_lock_pkg::STRIDE_WIDTH-1:0] i_cfg_tune_stride,
  // Trigger and stop
  input  logic                                   i_trig_val,
  output logic                                   o_trig_rdy,
  input  logic                                   i_lock_stop,
  // Tune handshake
  output logic                                   o_tune_val,
  input  logic                                   i_tune_ack,
  output ring_lock_pkg::tune_code_t              o_ring_tune,
  // Commit handshake
  output logic                                   o_commit_rdy,
  input  logic                                   i_commit_ack,
  input  ring_lock_pkg::pwr_t                    i_pwr_commit,
  output logic                                   o_locked
);

  // ----------------------------------------------------------------------
  // Internal wiring
  // ----------------------------------------------------------------------
  lock_step_if step_bus ();

  ring_lock_pkg::tune_code_t   cfg_start;
  ring_lock_pkg::tune_code_t   cfg_step;
  ring_lock_pkg::track_state_e track;
  ring_lock_pkg::slope_dir_e   dir;

  // ----------------------------------------------------------------------
  // Blocks
  // ----------------------------------------------------------------------
  lock_sequencer u_seq (
    .i_clk        (i_clk),
    .i_rst        (i_rst),
    .i_trig_val   (i_trig_val),
    .o_trig_rdy   (o_trig_rdy),
    .i_lock_stop  (i_lock_stop),
    .i_tune_ack   (i_tune_ack),
    .o_tune_val   (o_tune_val),
    .i_commit_ack (i_commit_ack),
    .o_commit_rdy (o_commit_rdy),
    .i_pwr_commit (i_pwr_commit),
    .o_locked     (o_locked),
    .step         (step_bus.seq)
  );

  // Config snapshot at refresh
  lock_cfg_regs u_cfg (
    .i_clk             (i_clk),
    .i_rst             (i_rst),
    .i_cfg_tune_start  (i_cfg_tune_start),
    .i_cfg_tune_stride (i_cfg_tune_stride),
    .i_refresh         (step_bus.refresh),
    .o_start           (cfg_start),
    .o_step            (cfg_step)
  );

  slope_window u_win (
    .i_clk   (i_clk),
    .i_rst   (i_rst),
    .step    (step_bus.dp),
    .o_track (track),
    .o_dir   (dir)
  );

  tune_code_gen u_tune (
    .i_clk       (i_clk),
    .i_rst       (i_rst),
    .step        (step_bus.dp),
    .i_start     (cfg_start),
    .i_step_size (cfg_step),
    .i_track     (track),
    .i_dir       (dir),
    .o_ring_tune (o_ring_tune)
  );

endmodule

/* tune_code_gen.sv */
// Ring tune code generator
module tune_code_gen (
  input  logic                        i_clk,
  input  logic                        i_rst,
  lock_step_if.dp                     step,
  input  ring_lock_pkg::tune_code_t   i_start,
  input  ring_lock_pkg::tune_code_t   i_step_size,
  input  ring_lock_pkg::track_state_e i_track,
  input  ring_lock_pkg::slope_dir_e   i_dir,
  output ring_lock_pkg::tune_code_t   o_ring_tune
);

  // Config regs hold start one cycle after refresh
  logic                      load_start;
  ring_lock_pkg::tune_code_t base;
  ring_lock_pkg::tune_code_t delta;
  // Values the compute step works from
  ring_lock_pkg::tune_code_t base_src;
  ring_lock_pkg::tune_code_t delta_src;
  ring_lock_pkg::tune_code_t base_nx;
  ring_lock_pkg::tune_code_t delta_nx;

  always_ff @(posedge i_clk or posedge i_rst) begin
    if (i_rst) begin
      load_start <= 1'b0;
    end else begin
      load_start <= step.refresh;
    end
  end

  // Load may land on the first compute cycle, so fold it in here
  assign base_src  = load_start ? i_start : base;
  assign delta_src = load_start ? '0 : delta;

  // ----------------------------------------------------------------------
  // Next base and delta
  // ----------------------------------------------------------------------
  always_comb begin
    base_nx  = base_src;
    delta_nx = delta_src;
    if (step.compute) begin
      if (i_track == ring_lock_pkg::TRACK_DELTA) begin
        // Ramp one step further
        delta_nx = delta_src + i_step_size;
      end else begin
        // Decision step, move base and restart the ramp
        case (i_dir)
          ring_lock_pkg::SLOPE_RED:  base_nx = base_src + i_step_size;
          ring_lock_pkg::SLOPE_BLUE: base_nx = base_src - i_step_size;
          default:                   base_nx = base_src;
        endcase
        delta_nx = '0;
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (load_start || step.compute) begin
      base  <= base_nx;
      delta <= delta_nx;
    end
  end

  // Registered code, wraps mod 2**DAC_WIDTH, stable through tune val
  always_ff @(posedge i_clk or posedge i_rst) begin
    if (i_rst) begin
      o_ring_tune <= '0;
    end else if (step.compute) begin
      o_ring_tune <= base_nx + delta_nx;
    end
  end

endmodule

/* slope_window.sv */
// Slope window and majority vote
module slope_window (
  input  logic                        i_clk,
  input  logic                        i_rst,
  lock_step_if.dp                     step,
  output ring_lock_pkg::track_state_e o_track,
  output ring_lock_pkg::slope_dir_e   o_dir
);

  // ----------------------------------------------------------------------
  // Window state
  // ----------------------------------------------------------------------
  // Newest flag in bit 0
  logic [ring_lock_pkg::WINDOW_SIZE-1:0] rise_win;
  logic [ring_lock_pkg::WINDOW_SIZE-1:0] fall_win;
  // Previous committed sample and its valid bit
  ring_lock_pkg::pwr_t                   pwr_prev;
  logic                                  prev_vld;
  // Commits seen in the current ramp
  logic [ring_lock_pkg::CNT_WIDTH-1:0]   cnt;
  logic [ring_lock_pkg::CNT_WIDTH-1:0]   cnt_inc;
  logic                                  delta_commit;
  logic                                  rise_now;
  logic                                  fall_now;
  logic                                  rise_vote;
  logic                                  fall_vote;

  assign delta_commit = step.commit && (o_track == ring_lock_pkg::TRACK_DELTA);
  assign cnt_inc      = cnt + 1'b1;

  // Strict compare, equal power gives neither flag
  assign rise_now = step.pwr_commit > pwr_prev;
  assign fall_now = step.pwr_commit < pwr_prev;

  // ----------------------------------------------------------------------
  // Sample and flag shift
  // ----------------------------------------------------------------------
  always_ff @(posedge i_clk or posedge i_rst) begin
    if (i_rst) begin
      rise_win <= '0;
      fall_win <= '0;
      prev_vld <= 1'b0;
    end else if (step.refresh) begin
      rise_win <= '0;
      fall_win <= '0;
      prev_vld <= 1'b0;
    end else if (delta_commit) begin
      prev_vld <= 1'b1;
      // First sample after refresh has nothing to compare with
      if (prev_vld) begin
        rise_win <= {rise_win[ring_lock_pkg::WINDOW_SIZE-2:0], rise_now};
        fall_win <= {fall_win[ring_lock_pkg::WINDOW_SIZE-2:0], fall_now};
      end
    end
  end

  // Sample payload, only meaningful behind prev_vld
  always_ff @(posedge i_clk) begin
    if (step.refresh) begin
      pwr_prev <= '0;
    end else if (delta_commit) begin
      pwr_prev <= step.pwr_commit;
    end
  end

  // ----------------------------------------------------------------------
  // Track state and commit counter
  // ----------------------------------------------------------------------
  always_ff @(posedge i_clk or posedge i_rst) begin
    if (i_rst) begin
      o_track <= ring_lock_pkg::TRACK_DELTA;
      cnt     <= '0;
    end else if (step.refresh) begin
      o_track <= ring_lock_pkg::TRACK_DELTA;
      cnt     <= '0;
    end else if (step.commit) begin
      if (o_track == ring_lock_pkg::TRACK_DELTA) begin
        cnt <= cnt_inc;
        // Window full, next compute takes the decision
        if (cnt_inc == ring_lock_pkg::WINDOW_SIZE) o_track <= ring_lock_pkg::TRACK_DETECT;
      end else begin
        o_track <= ring_lock_pkg::TRACK_DELTA;
        cnt     <= '0;
      end
    end
  end

  // ----------------------------------------------------------------------
  // Majority vote, combinational from the windows
  // ----------------------------------------------------------------------
  assign rise_vote = $countones(rise_win) >= ring_lock_pkg::VOTE_THRES;
  assign fall_vote = $countones(fall_win) >= ring_lock_pkg::VOTE_THRES;

  always_comb begin
    case ({rise_vote, fall_vote})
      2'b10:   o_dir = ring_lock_pkg::SLOPE_RED;
      2'b01:   o_dir = ring_lock_pkg::SLOPE_BLUE;
      // Both or neither, stay put
      default: o_dir = ring_lock_pkg::SLOPE_HOLD;
    endcase
  end

endmodule

/* lock_sequencer.sv */
// Lock sequencer FSM
module lock_sequencer (
  input  logic                 i_clk,
  input  logic                 i_rst,
  // Trigger handshake
  input  logic                 i_trig_val,
  output logic                 o_trig_rdy,
  input  logic                 i_lock_stop,
  // Tune handshake
  input  logic                 i_tune_ack,
  output logic                 o_tune_val,
  // Commit handshake
  input  logic                 i_commit_ack,
  output logic                 o_commit_rdy,
  input  ring_lock_pkg::pwr_t  i_pwr_commit,
  output logic                 o_locked,
  lock_step_if.seq             step
);

  ring_lock_pkg::lock_state_e state;
  ring_lock_pkg::lock_state_e state_nx;
  ring_lock_pkg::ctrl_phase_e phase;
  ring_lock_pkg::ctrl_phase_e phase_nx;

  logic trig_fire;
  logic tune_fire;
  logic commit_fire;
  logic is_active;
  logic is_tune;
  logic is_update;
  // Set once the tune code has been computed in this tune phase
  logic compute_done;

  // ----------------------------------------------------------------------
  // Top lock FSM
  // ----------------------------------------------------------------------
  assign o_trig_rdy = (state == ring_lock_pkg::LOCK_IDLE);
  assign trig_fire  = o_trig_rdy && i_trig_val;
  assign is_active  = (state == ring_lock_pkg::LOCK_ACTIVE);

  always_comb begin
    state_nx = state;
    case (state)
      ring_lock_pkg::LOCK_IDLE:   if (trig_fire) state_nx = ring_lock_pkg::LOCK_INIT;
      // Single-cycle init
      ring_lock_pkg::LOCK_INIT:   state_nx = ring_lock_pkg::LOCK_ACTIVE;
      ring_lock_pkg::LOCK_ACTIVE: if (i_lock_stop) state_nx = ring_lock_pkg::LOCK_IDLE;
      default:                    state_nx = ring_lock_pkg::LOCK_IDLE;
    endcase
  end

  always_ff @(posedge i_clk or posedge i_rst) begin
    if (i_rst) begin
      state <= ring_lock_pkg::LOCK_IDLE;
    end else begin
      state <= state_nx;
    end
  end

  // ----------------------------------------------------------------------
  // Tune / commit phase
  // ----------------------------------------------------------------------
  assign is_tune   = is_active && (phase == ring_lock_pkg::CTRL_TUNE);
  assign is_update = is_active && (phase == ring_lock_pkg::CTRL_UPDATE);

  // Acks outside their own phase are dropped here
  assign tune_fire   = o_tune_val && i_tune_ack;
  assign commit_fire = o_commit_rdy && i_commit_ack;

  always_comb begin
    phase_nx = phase;
    if (is_active) begin
      case (phase)
        ring_lock_pkg::CTRL_TUNE:   if (tune_fire) phase_nx = ring_lock_pkg::CTRL_UPDATE;
        ring_lock_pkg::CTRL_UPDATE: if (commit_fire) phase_nx = ring_lock_pkg::CTRL_TUNE;
        default:                    phase_nx = ring_lock_pkg::CTRL_TUNE;
      endcase
    end
  end

  // Refresh restarts the loop in the tune phase
  always_ff @(posedge i_clk or posedge i_rst) begin
    if (i_rst) begin
      phase        <= ring_lock_pkg::CTRL_TUNE;
      compute_done <= 1'b0;
    end else if (step.refresh) begin
      phase        <= ring_lock_pkg::CTRL_TUNE;
      compute_done <= 1'b0;
    end else begin
      phase <= phase_nx;
      // One compute cycle per tune phase, rearmed in update
      if (is_tune) begin
        compute_done <= 1'b1;
      end else if (is_update) begin
        compute_done <= 1'b0;
      end
    end
  end

  // ----------------------------------------------------------------------
  // Outputs and step strobes
  // ----------------------------------------------------------------------
  // val follows the compute cycle, code is registered by then
  assign o_tune_val   = is_tune && compute_done;
  assign o_commit_rdy = is_update;
  assign o_locked     = is_active;

  assign step.refresh    = (state == ring_lock_pkg::LOCK_INIT);
  assign step.compute    = is_tune && !compute_done;
  assign step.commit     = commit_fire;
  assign step.pwr_commit = i_pwr_commit;

endmodule

/* lock_cfg_regs.sv */
// Lock configuration registers
module lock_cfg_regs (
  input  logic                                    i_clk,
  input  logic                                    i_rst,
  input  ring_lock_pkg::tune_code_t               i_cfg_tune_start,
  input  logic [ring_lock_pkg::STRIDE_WIDTH-1:0]  i_cfg_tune_stride,
  input  logic                                    i_refresh,
  output ring_lock_pkg::tune_code_t               o_start,
  output ring_lock_pkg::tune_code_t               o_step
);

  // ----------------------------------------------------------------------
  // Step decode
  // ----------------------------------------------------------------------
  ring_lock_pkg::tune_code_t step_dec;

  // Power-of-two step from the stride exponent
  // stride above DAC_WIDTH-1 shifts the bit out, step becomes zero
  always_comb begin
    step_dec = ring_lock_pkg::tune_code_t'(1) << i_cfg_tune_stride;
  end

  // ----------------------------------------------------------------------
  // Per-lock snapshot
  // ----------------------------------------------------------------------
  // Captured only on refresh
  // Config pins may move during a lock without effect
  always_ff @(posedge i_clk or posedge i_rst) begin
    if (i_rst) begin
      o_start <= '0;
      o_step  <= '0;
    end else if (i_refresh) begin
      o_start <= i_cfg_tune_start;
      o_step  <= step_dec;
    end
  end

  // Values valid one cycle after refresh
  // tune_code_gen loads the base on that cycle

endmodule

/* lock_step_if.sv */
// Lock step control bus
interface lock_step_if;

  // ----------------------------------------------------------------------
  // Step strobes, all single-cycle pulses
  // ----------------------------------------------------------------------
  // Lock init, clears datapath state
  logic refresh;
  // First cycle of each tune phase
  logic compute;
  // Commit acknowledge accepted
  logic commit;
  // Power sample taken with the commit
  ring_lock_pkg::pwr_t pwr_commit;

  // Sequencer side
  modport seq (
    output refresh,
    output compute,
    output commit,
    output pwr_commit
  );

  // Window and tune datapath side
  modport dp (
    input refresh,
    input compute,
    input commit,
    input pwr_commit
  );

endinterface

/* ring_lock_pkg.sv */
// Ring lock shared definitions
package ring_lock_pkg;

  // ----------------------------------------------------------------------
  // Widths and window constants
  // ----------------------------------------------------------------------
  // Tune DAC code and power sample widths
  localparam int DAC_WIDTH    = 8;
  localparam int PWR_WIDTH    = 8;
  // Step exponent, step = 2**stride
  localparam int STRIDE_WIDTH = 3;
  // Commits per ramp window and votes needed to win
  localparam int WINDOW_SIZE  = 4;
  localparam int VOTE_THRES   = 2;
  // Window counter, must reach WINDOW_SIZE
  localparam int CNT_WIDTH    = 3;

  // ----------------------------------------------------------------------
  // Data types
  // ----------------------------------------------------------------------
  typedef logic [DAC_WIDTH-1:0] tune_code_t;
  typedef logic [PWR_WIDTH-1:0] pwr_t;

  // Top lock FSM
  typedef enum logic [1:0] {LOCK_IDLE, LOCK_INIT, LOCK_ACTIVE} lock_state_e;

  // Handshake phase inside LOCK_ACTIVE
  typedef enum logic {CTRL_TUNE, CTRL_UPDATE} ctrl_phase_e;

  // Ramp phase, then one decision step
  typedef enum logic {TRACK_DELTA, TRACK_DETECT} track_state_e;

  // Vote result
  // RED means power rose along the ramp, BLUE means it fell
  typedef enum logic [1:0] {SLOPE_HOLD, SLOPE_RED, SLOPE_BLUE} slope_dir_e;

endpackage
